/* design/arcade_inputs.sv */
`timescale 1ns/1ns
`default_nettype none

module arcade_inputs (
	input  wire                  clk_sys,
	input  wire                  reset,
	settings_if.user             set,
	input  wire                  key_strobe,
	input  wire                  key_pressed,
	input  wire maze_pkg::key_code_t key_code,
	input  wire maze_pkg::joy_t  joystick_0,
	input  wire maze_pkg::joy_t  joystick_1,
	output maze_pkg::player_t    player1,
	output maze_pkg::player_t    player2,
	output logic                 coin,
	output logic                 start1
);

	maze_pkg::player_t held_keys;
	maze_pkg::player_t held_keys_next;
	logic              held_coin;
	logic              held_coin_next;
	logic              held_start;
	logic              held_start_next;
	maze_pkg::joy_t    joy_a;
	maze_pkg::joy_t    joy_b;

	function automatic maze_pkg::player_t joy_to_player(input maze_pkg::joy_t j);
		maze_pkg::player_t p;
		p = '0;
		p[maze_pkg::PL_UP]    = j[maze_pkg::JOY_UP];
		p[maze_pkg::PL_DOWN]  = j[maze_pkg::JOY_DOWN];
		p[maze_pkg::PL_LEFT]  = j[maze_pkg::JOY_LEFT];
		p[maze_pkg::PL_RIGHT] = j[maze_pkg::JOY_RIGHT];
		p[maze_pkg::PL_FIRE]  = j[maze_pkg::JOY_FIRE];
		return p;
	endfunction

	// Key state after this cycle's strobe, so the outputs follow a strobe in one cycle
	always_comb begin
		held_keys_next  = held_keys;
		held_coin_next  = held_coin;
		held_start_next = held_start;
		if (key_strobe) begin
			case (key_code)
				maze_pkg::KEY_UP:     held_keys_next[maze_pkg::PL_UP]    = key_pressed;
				maze_pkg::KEY_DOWN:   held_keys_next[maze_pkg::PL_DOWN]  = key_pressed;
				maze_pkg::KEY_LEFT:   held_keys_next[maze_pkg::PL_LEFT]  = key_pressed;
				maze_pkg::KEY_RIGHT:  held_keys_next[maze_pkg::PL_RIGHT] = key_pressed;
				maze_pkg::KEY_FIRE:   held_keys_next[maze_pkg::PL_FIRE]  = key_pressed;
				maze_pkg::KEY_COIN:   held_coin_next  = key_pressed;
				maze_pkg::KEY_START1: held_start_next = key_pressed;
				default: ;
			endcase
		end
	end

	assign joy_a = set.joyswap ? joystick_1 : joystick_0;
	assign joy_b = set.joyswap ? joystick_0 : joystick_1;

	// Held keys survive a game reset since the keys are still physically down
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			held_keys  <= '0;
			held_coin  <= 1'b0;
			held_start <= 1'b0;
		end else begin
			held_keys  <= held_keys_next;
			held_coin  <= held_coin_next;
			held_start <= held_start_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || set.game_reset) begin
			player1 <= '0;
			player2 <= '0;
			coin    <= 1'b0;
			start1  <= 1'b0;
		end else begin
			player1 <= held_keys_next | joy_to_player(joy_a);
			player2 <= joy_to_player(joy_b);
			coin    <= held_coin_next;
			start1  <= held_start_next;
		end
	end

endmodule

`default_nettype wire

/* design/maze_io_top.sv */
`timescale 1ns/1ns
`default_nettype none

module maze_io_top #(
	parameter int RESET_CYCLES = 4
) (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      cfg_valid,
	input  wire  [7:0]               cfg_data,
	output logic                     cfg_ready,
	input  wire                      key_strobe,
	input  wire                      key_pressed,
	input  wire maze_pkg::key_code_t key_code,
	input  wire maze_pkg::joy_t      joystick_0,
	input  wire maze_pkg::joy_t      joystick_1,
	input  wire                      video,
	input  wire                      hsync,
	input  wire                      vsync,
	input  wire maze_pkg::sample_t   sample,
	output maze_pkg::player_t        player1,
	output maze_pkg::player_t        player2,
	output logic                     coin,
	output logic                     start1,
	output logic                     game_reset,
	output maze_pkg::color_t         vga_r,
	output maze_pkg::color_t         vga_g,
	output maze_pkg::color_t         vga_b,
	output logic                     vga_hs,
	output logic                     vga_vs,
	output logic                     audio_out
);

	settings_if set_bus ();

	status_regs #(
		.RESET_CYCLES(RESET_CYCLES)
	) regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cfg_valid (cfg_valid),
		.cfg_data  (cfg_data),
		.cfg_ready (cfg_ready),
		.set       (set_bus.regs)
	);

	arcade_inputs inputs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.set         (set_bus.user),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.player1     (player1),
		.player2     (player2),
		.coin        (coin),
		.start1      (start1)
	);

	scanline_video video_out (
		.clk_sys (clk_sys),
		.reset   (reset),
		.set     (set_bus.user),
		.video   (video),
		.hsync   (hsync),
		.vsync   (vsync),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	sigma_delta_dac dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.set       (set_bus.user),
		.sample    (sample),
		.audio_out (audio_out)
	);

	// The game core outside this shell is held in reset by this pulse
	assign game_reset = set_bus.game_reset;

endmodule

`default_nettype wire

/* design/maze_pkg.sv */
`default_nettype none

package maze_pkg;

	// VGA color channel, audio sample and input words
	typedef logic [5:0] color_t;
	typedef logic [7:0] sample_t;
	typedef logic [7:0] key_code_t;
	typedef logic [7:0] joy_t;
	typedef logic [4:0] player_t;
	typedef logic [1:0] scan_level_t;

	// Joystick word bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// Player control bit positions, up is the most significant bit
	localparam int PL_FIRE  = 0;
	localparam int PL_RIGHT = 1;
	localparam int PL_LEFT  = 2;
	localparam int PL_DOWN  = 3;
	localparam int PL_UP    = 4;

	// PS/2 set 2 scan codes, arrows without the E0 prefix
	localparam key_code_t KEY_UP     = 8'h75;
	localparam key_code_t KEY_DOWN   = 8'h72;
	localparam key_code_t KEY_LEFT   = 8'h6b;
	localparam key_code_t KEY_RIGHT  = 8'h74;
	localparam key_code_t KEY_FIRE   = 8'h14;
	localparam key_code_t KEY_COIN   = 8'h2e;
	localparam key_code_t KEY_START1 = 8'h16;

	// Field positions in the host settings word
	localparam int SET_RESET   = 0;
	localparam int SET_SCAN_LO = 3;
	localparam int SET_JOYSWAP = 6;
	localparam int SET_MUTE    = 7;

	localparam int     DIM_STEP   = 16;
	localparam color_t COLOR_FULL = 6'h3f;

endpackage

`default_nettype wire

/* design/scanline_video.sv */
`timescale 1ns/1ns
`default_nettype none

module scanline_video (
	input  wire                clk_sys,
	input  wire                reset,
	settings_if.user           set,
	input  wire                video,
	input  wire                hsync,
	input  wire                vsync,
	output maze_pkg::color_t   vga_r,
	output maze_pkg::color_t   vga_g,
	output maze_pkg::color_t   vga_b,
	output logic               vga_hs,
	output logic               vga_vs
);

	logic             line_odd;
	logic             hs_fall;
	logic             vs_fall;
	maze_pkg::color_t lit_level;
	maze_pkg::color_t pixel;

	// The registered syncs hold last cycle's inputs, which is all the edge detect needs
	assign hs_fall = vga_hs && !hsync;
	assign vs_fall = vga_vs && !vsync;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			line_odd <= 1'b0;
		end else if (vs_fall) begin
			line_odd <= 1'b0;
		end else if (hs_fall) begin
			line_odd <= !line_odd;
		end
	end

	// Odd lines lose DIM_STEP per scanline level, the pixel uses the parity held before any edge
	assign lit_level = line_odd ?
		maze_pkg::color_t'(int'(maze_pkg::COLOR_FULL) -
			maze_pkg::DIM_STEP * int'(set.scan_level)) :
		maze_pkg::COLOR_FULL;

	assign pixel = video ? lit_level : '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= pixel;
			vga_g  <= pixel;
			vga_hs <= hsync;
			vga_vs <= vsync;
		end
	end

	// Red plus green gives the yellow maze, blue is never lit
	assign vga_b = '0;

endmodule

`default_nettype wire

/* design/settings_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface settings_if;

	maze_pkg::scan_level_t scan_level;
	logic                  joyswap;
	logic                  mute;
	logic                  game_reset;

	modport regs (
		output scan_level,
		output joyswap,
		output mute,
		output game_reset
	);

	// Each block reads only the fields that steer it
	modport user (
		input scan_level,
		input joyswap,
		input mute,
		input game_reset
	);

endinterface

`default_nettype wire

/* design/sigma_delta_dac.sv */
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac (
	input  wire                 clk_sys,
	input  wire                 reset,
	settings_if.user            set,
	input  wire maze_pkg::sample_t sample,
	output logic                audio_out
);

	logic [8:0]        acc;
	maze_pkg::sample_t sample_eff;

	assign sample_eff = set.mute ? '0 : sample;

	// Over 256 cycles the low byte wraps exactly sample times, one carry each
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[7:0]} + {1'b0, sample_eff};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || set.mute) begin
			audio_out <= 1'b0;
		end else begin
			audio_out <= acc[8];
		end
	end

endmodule

`default_nettype wire

/* design/status_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module status_regs #(
	parameter int RESET_CYCLES = 4
) (
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        cfg_valid,
	input  wire  [7:0] cfg_data,
	output logic       cfg_ready,
	settings_if.regs   set
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 1);

	logic [CNT_W-1:0] rst_cnt;
	logic             cfg_write;

	assign cfg_write = cfg_valid && cfg_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			set.scan_level <= '0;
			set.joyswap    <= 1'b0;
			set.mute       <= 1'b0;
		end else if (cfg_write) begin
			set.scan_level <= cfg_data[maze_pkg::SET_SCAN_LO +: $bits(maze_pkg::scan_level_t)];
			set.joyswap    <= cfg_data[maze_pkg::SET_JOYSWAP];
			set.mute       <= cfg_data[maze_pkg::SET_MUTE];
		end
	end

	// The counter is loaded by a write with the reset bit and counts down to zero
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rst_cnt <= '0;
		end else if (cfg_write && cfg_data[maze_pkg::SET_RESET]) begin
			rst_cnt <= CNT_W'(RESET_CYCLES);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	assign set.game_reset = (rst_cnt != '0);

	// No further writes are taken while the game core is held in reset
	assign cfg_ready = (rst_cnt == '0);

endmodule

`default_nettype wire

/* src.f */
design/maze_pkg.sv
design/settings_if.sv
design/status_regs.sv
design/arcade_inputs.sv
design/scanline_video.sv
design/sigma_delta_dac.sv
design/maze_io_top.sv
verif/clk_gen.sv
verif/maze_io_assertions.sv
verif/tb_maze_io.sv

/* verif/clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
	parameter int PERIOD    = 40,
	parameter int RESET_LEN = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_LEN) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* verif/maze_io_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module maze_io_assertions #(
	parameter int RESET_CYCLES = 4
) (
	input wire clk_sys,
	input wire reset,
	input wire cfg_valid,
	input wire cfg_ready,
	input wire game_reset
);

	logic first_write_seen;
	int   fail_count = 0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			first_write_seen <= 1'b0;
		end else if (cfg_valid && cfg_ready) begin
			first_write_seen <= 1'b1;
		end
	end

	ready_until_first_write: assert property (@(posedge clk_sys) disable iff (reset)
		!first_write_seen |-> cfg_ready)
		else begin
			$error("cfg_ready dropped before the first settings write");
			fail_count++;
		end

	pulse_length: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(game_reset) |-> game_reset [*RESET_CYCLES] ##1 !game_reset)
		else begin
			$error("game_reset pulse has the wrong length");
			fail_count++;
		end

	ready_low_in_reset: assert property (@(posedge clk_sys) disable iff (reset)
		game_reset |-> !cfg_ready)
		else begin
			$error("cfg_ready high while game_reset is active");
			fail_count++;
		end

endmodule

bind status_regs maze_io_assertions #(.RESET_CYCLES(RESET_CYCLES)) handshake_checks (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cfg_valid  (cfg_valid),
	.cfg_ready  (cfg_ready),
	.game_reset (set.game_reset)
);

`default_nettype wire

/* verif/tb_maze_io.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_maze_io;

	localparam int RESET_CYCLES = 4;
	// Rough cycle budget of all tests, the watchdog adds a margin on top
	localparam int TEST_CYCLES     = 40 * 12 + 330 + 2 * 210 + 130 + 4 * 170 + 8 * 265;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 500;

	logic clk_sys;
	logic reset;
	logic cfg_valid;
	logic [7:0] cfg_data;
	logic cfg_ready;
	logic key_strobe;
	logic key_pressed;
	maze_pkg::key_code_t key_code;
	maze_pkg::joy_t joystick_0;
	maze_pkg::joy_t joystick_1;
	logic video;
	logic hsync;
	logic vsync;
	maze_pkg::sample_t sample;
	maze_pkg::player_t player1;
	maze_pkg::player_t player2;
	logic coin;
	logic start1;
	logic game_reset;
	maze_pkg::color_t vga_r;
	maze_pkg::color_t vga_g;
	maze_pkg::color_t vga_b;
	logic vga_hs;
	logic vga_vs;
	logic audio_out;

	logic [31:0] lfsr = 32'he6eb_4d91;
	int n_checks = 0;
	int n_errors = 0;
	int checks_mark = 0;
	int errors_mark = 0;

	// Settings model, both values describe the DUT after the next rising edge
	logic [7:0] model_set = '0;
	int pulse_left = 0;
	logic model_live = 1'b0;

	maze_pkg::player_t key_model = '0;
	logic coin_model = 1'b0;
	logic start_model = 1'b0;
	logic line_odd_model = 1'b0;
	logic hs_prev = 1'b1;
	logic vs_prev = 1'b1;

	clk_gen #(.PERIOD(40), .RESET_LEN(8)) clocks (.clk(clk_sys), .reset(reset));

	maze_io_top #(.RESET_CYCLES(RESET_CYCLES)) DUT (.*);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Mostly mapped codes, one draw in eight is any byte
	function automatic maze_pkg::key_code_t pick_key();
		logic [2:0] idx;
		idx = rand_bits(3);
		case (idx)
			3'd0: return maze_pkg::KEY_UP;
			3'd1: return maze_pkg::KEY_DOWN;
			3'd2: return maze_pkg::KEY_LEFT;
			3'd3: return maze_pkg::KEY_RIGHT;
			3'd4: return maze_pkg::KEY_FIRE;
			3'd5: return maze_pkg::KEY_COIN;
			3'd6: return maze_pkg::KEY_START1;
			default: return rand_bits(8);
		endcase
	endfunction

	// Player order is up, down, left, right, fire
	function automatic maze_pkg::player_t joy_map(input maze_pkg::joy_t j);
		return {j[3], j[2], j[1], j[0], j[4]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d checks, %0d errors", name, n_checks - checks_mark,
			n_errors - errors_mark);
		checks_mark = n_checks;
		errors_mark = n_errors;
	endtask

	always @(negedge clk_sys) begin
		if (model_live) begin
			check_value("cfg_ready", cfg_ready, pulse_left == 0);
			check_value("game_reset", game_reset, pulse_left != 0);
		end
		if (reset) begin
			pulse_left = 0;
			model_set = '0;
			model_live = 1'b1;
		end else if (cfg_valid && pulse_left == 0) begin
			model_set = cfg_data;
			pulse_left = cfg_data[maze_pkg::SET_RESET] ? RESET_CYCLES : 0;
		end else if (pulse_left != 0) begin
			pulse_left--;
		end
	end

	task automatic write_settings(input logic [7:0] data);
		cfg_valid <= 1'b1;
		cfg_data <= data;
		@(negedge clk_sys);
		while (!cfg_ready) @(negedge clk_sys);
		@(posedge clk_sys);
		cfg_valid <= 1'b0;
	endtask

	// Expected controls are packed as {player1, player2, coin, start1}
	task automatic drive_controls(input int cycles, input int reset_at);
		logic [11:0] exp_now;
		logic [11:0] exp_prev;
		logic strobe;
		logic pressed;
		logic swap;
		maze_pkg::key_code_t code;
		maze_pkg::joy_t j0;
		maze_pkg::joy_t j1;
		exp_now = '0;
		for (int i = 0; i <= cycles; i++) begin
			if (i < cycles) begin
				strobe = rand_bits(1);
				pressed = rand_bits(1);
				code = pick_key();
				j0 = rand_bits(8);
				j1 = rand_bits(8);
				key_strobe <= strobe;
				key_pressed <= pressed;
				key_code <= code;
				joystick_0 <= j0;
				joystick_1 <= j1;
				cfg_valid <= (i == reset_at);
				cfg_data <= model_set | 8'(1 << maze_pkg::SET_RESET);
				if (strobe) begin
					case (code)
						maze_pkg::KEY_UP:     key_model[4] = pressed;
						maze_pkg::KEY_DOWN:   key_model[3] = pressed;
						maze_pkg::KEY_LEFT:   key_model[2] = pressed;
						maze_pkg::KEY_RIGHT:  key_model[1] = pressed;
						maze_pkg::KEY_FIRE:   key_model[0] = pressed;
						maze_pkg::KEY_COIN:   coin_model = pressed;
						maze_pkg::KEY_START1: start_model = pressed;
						default: ;
					endcase
				end
				swap = model_set[maze_pkg::SET_JOYSWAP];
				exp_now = {key_model | joy_map(swap ? j1 : j0), joy_map(swap ? j0 : j1),
					coin_model, start_model};
				if (pulse_left != 0) begin
					exp_now = '0;
				end
			end else begin
				key_strobe <= 1'b0;
				cfg_valid <= 1'b0;
			end
			@(negedge clk_sys);
			if (i > 0) begin
				check_value("player1", player1, exp_prev[11:7]);
				check_value("player2", player2, exp_prev[6:2]);
				check_value("coin", coin, exp_prev[1]);
				check_value("start1", start1, exp_prev[0]);
			end
			exp_prev = exp_now;
			@(posedge clk_sys);
		end
	endtask

	// Lines are 16 cycles with a 2 cycle hsync, every fifth line carries vsync
	task automatic sweep_video(input int cycles);
		logic [7:0] exp_now;
		logic [7:0] exp_prev;
		logic vid;
		logic hs;
		logic vs;
		int level;
		exp_now = '0;
		for (int i = 0; i <= cycles; i++) begin
			if (i < cycles) begin
				vid = rand_bits(1);
				hs = (i % 16) < 14;
				vs = ((i / 16) % 5) != 0;
				video <= vid;
				hsync <= hs;
				vsync <= vs;
				level = 63;
				if (line_odd_model) begin
					level = 63 - maze_pkg::DIM_STEP * model_set[maze_pkg::SET_SCAN_LO +: 2];
				end
				exp_now = {vid ? 6'(level) : 6'd0, hs, vs};
				if (vs_prev && !vs) begin
					line_odd_model = 1'b0;
				end else if (hs_prev && !hs) begin
					line_odd_model = !line_odd_model;
				end
				hs_prev = hs;
				vs_prev = vs;
			end else begin
				video <= 1'b0;
				hsync <= 1'b1;
				vsync <= 1'b1;
				hs_prev = 1'b1;
				vs_prev = 1'b1;
			end
			@(negedge clk_sys);
			if (i > 0) begin
				check_value("vga_r", vga_r, exp_prev[7:2]);
				check_value("vga_g", vga_g, exp_prev[7:2]);
				check_value("vga_b", vga_b, 0);
				check_value("vga_hs", vga_hs, exp_prev[1]);
				check_value("vga_vs", vga_vs, exp_prev[0]);
			end
			exp_prev = exp_now;
			@(posedge clk_sys);
		end
	endtask

	task automatic count_audio_ones(input logic [7:0] s, input logic muted);
		int ones;
		sample <= s;
		repeat (4) @(posedge clk_sys);
		ones = 0;
		repeat (256) begin
			@(negedge clk_sys);
			ones += audio_out;
		end
		check_value("audio_out ones", ones, muted ? 0 : s);
		@(posedge clk_sys);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired before the tests finished");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		cfg_valid = 1'b0;
		cfg_data = '0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		video = 1'b0;
		hsync = 1'b1;
		vsync = 1'b1;
		sample = '0;
		wait (!reset);
		@(posedge clk_sys);

		// A zero gap after a reset write presents the next write while cfg_ready is low
		for (int i = 0; i < 40; i++) begin
			repeat (rand_bits(2)) @(posedge clk_sys);
			write_settings(rand_bits(8));
		end
		repeat (RESET_CYCLES + 2) @(posedge clk_sys);
		// The fields of the last random write steer the swap, the dimming and the mute
		drive_controls(20, -1);
		sweep_video(40);
		count_audio_ones(8'h80 | rand_bits(7), model_set[maze_pkg::SET_MUTE]);
		report_test("settings writes");

		write_settings(8'h00);
		drive_controls(200, -1);
		write_settings(8'(1 << maze_pkg::SET_JOYSWAP));
		drive_controls(200, -1);
		report_test("player controls");

		drive_controls(120, 30);
		report_test("controls in game reset");

		for (int lvl = 0; lvl < 4; lvl++) begin
			write_settings(8'(lvl << maze_pkg::SET_SCAN_LO));
			sweep_video(160);
		end
		report_test("scanline video");

		write_settings(8'h00);
		for (int i = 0; i < 6; i++) begin
			count_audio_ones(rand_bits(8), 1'b0);
		end
		write_settings(8'(1 << maze_pkg::SET_MUTE));
		count_audio_ones(8'h80 | rand_bits(7), 1'b1);
		report_test("sigma-delta audio");

		if (DUT.regs.handshake_checks.fail_count != 0) begin
			$display("Bound handshake assertions failed %0d times",
				DUT.regs.handshake_checks.fail_count);
			n_errors += DUT.regs.handshake_checks.fail_count;
		end

		$display("Total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
